// ==== recovery_mbox_pkg.sv ====
/* Register map, AXI response codes and the STATUS word layout of the mailbox.
   Offsets are 12-bit byte offsets. STATUS fields limit the FIFO to 63 entries */
package recovery_mbox_pkg;

  // Register width, also the AXI data width
  localparam int unsigned CSR_DATA_W = 32;

  // Register offsets
  localparam logic [11:0] CTRL_OFFS    = 12'h000; // bit 0 clears the FIFO
  localparam logic [11:0] STATUS_OFFS  = 12'h004; // read only
  localparam logic [11:0] DATA_OFFS    = 12'h008; // indirect FIFO port
  localparam logic [11:0] SCRATCH_OFFS = 12'h00C;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // STATUS word, built field by field and returned raw
  typedef union packed {
    logic [CSR_DATA_W-1:0] raw;
    struct packed {
      logic [15:0] reserved;
      logic [7:0]  level;    // Words in the FIFO
      logic        full;
      logic        empty;
      logic [5:0]  credits;  // Pushes still allowed
    } fields;
  } status_word_u;

endpackage

// ==== axi_csr_adapter.sv ====
/* AXI4 slave for single-beat accesses with one transaction in flight.
   Bursts and writes without wlast get SLVERR and issue no request.
   A read wins over a write that arrives on the same cycle */
`timescale 1ns/1ps
module axi_csr_adapter #(
  parameter int unsigned AddrW = 12,
  parameter int unsigned IdW   = 4
) (
  input  logic                                         aclk,
  input  logic                                         areset_n,
  // Write address
  input  logic [AddrW-1:0]                             awaddr_i,
  input  logic [IdW-1:0]                               awid_i,
  input  logic [7:0]                                   awlen_i,
  input  logic                                         awvalid_i,
  output logic                                         awready_o,
  // Write data
  input  logic [recovery_mbox_pkg::CSR_DATA_W-1:0]     wdata_i,
  input  logic [recovery_mbox_pkg::CSR_DATA_W/8-1:0]   wstrb_i,
  input  logic                                         wlast_i,
  input  logic                                         wvalid_i,
  output logic                                         wready_o,
  // Write response
  output logic [1:0]                                   bresp_o,
  output logic [IdW-1:0]                               bid_o,
  output logic                                         bvalid_o,
  input  logic                                         bready_i,
  // Read address
  input  logic [AddrW-1:0]                             araddr_i,
  input  logic [IdW-1:0]                               arid_i,
  input  logic [7:0]                                   arlen_i,
  input  logic                                         arvalid_i,
  output logic                                         arready_o,
  // Read data
  output logic [recovery_mbox_pkg::CSR_DATA_W-1:0]     rdata_o,
  output logic [1:0]                                   rresp_o,
  output logic [IdW-1:0]                               rid_o,
  output logic                                         rlast_o,
  output logic                                         rvalid_o,
  input  logic                                         rready_i,
  // Register request port
  output logic                                         req_o,
  output logic                                         req_is_wr_o,
  output logic [AddrW-1:0]                             addr_o,
  output logic [recovery_mbox_pkg::CSR_DATA_W-1:0]     wr_data_o,
  output logic [recovery_mbox_pkg::CSR_DATA_W-1:0]     wr_biten_o,
  input  logic                                         ack_i,
  input  logic                                         err_i,
  input  logic [recovery_mbox_pkg::CSR_DATA_W-1:0]     rd_data_i
);
  import recovery_mbox_pkg::*;

  localparam logic [1:0] StIdle = 2'd0;
  localparam logic [1:0] StReq  = 2'd1;
  localparam logic [1:0] StWait = 2'd2;
  localparam logic [1:0] StResp = 2'd3;

  logic [1:0]              state_q;
  logic [1:0]              state_d;
  logic                    aw_held_q;
  logic                    w_held_q;
  logic                    is_wr_q;
  logic                    len_bad_q;
  logic                    wlast_q;
  logic [AddrW-1:0]        addr_q;
  logic [IdW-1:0]          id_q;
  logic [CSR_DATA_W-1:0]   wdata_q;
  logic [CSR_DATA_W/8-1:0] wstrb_q;
  logic [CSR_DATA_W-1:0]   rdata_q;
  logic [1:0]              resp_q;
  logic                    idle;
  logic                    ar_hs;
  logic                    aw_hs;
  logic                    w_hs;
  logic                    wr_start;
  logic                    req_bad;

  assign idle      = state_q == StIdle;
  // No read may start once half of a write is held
  assign arready_o = idle & ~aw_held_q & ~w_held_q;
  assign ar_hs     = arvalid_i & arready_o;
  assign awready_o = idle & ~aw_held_q & ~ar_hs;
  assign wready_o  = idle & ~w_held_q & ~ar_hs;
  assign aw_hs     = awvalid_i & awready_o;
  assign w_hs      = wvalid_i & wready_o;
  assign wr_start  = (aw_held_q | aw_hs) & (w_held_q | w_hs);
  assign req_bad   = len_bad_q | (is_wr_q & ~wlast_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: if (ar_hs || wr_start) state_d = StReq;
      StReq:  state_d = StWait;
      StWait: if (ack_i || req_bad) state_d = StResp; // Rejected beats skip the register block
      default: begin
        if ((is_wr_q && bready_i) || (!is_wr_q && rready_i)) state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      state_q   <= StIdle;
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      is_wr_q   <= 1'b0;
    end else begin
      state_q   <= state_d;
      aw_held_q <= ~wr_start & (aw_held_q | aw_hs);
      w_held_q  <= ~wr_start & (w_held_q | w_hs);
      if (ar_hs) is_wr_q <= 1'b0;
      else if (aw_hs) is_wr_q <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_hs) begin
      addr_q    <= araddr_i;
      id_q      <= arid_i;
      len_bad_q <= |arlen_i;
    end
    if (aw_hs) begin
      addr_q    <= awaddr_i;
      id_q      <= awid_i;
      len_bad_q <= |awlen_i;
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
      wlast_q <= wlast_i;
    end
    if (state_q == StWait && state_d == StResp) begin
      resp_q  <= (req_bad || err_i) ? RESP_SLVERR : RESP_OKAY;
      rdata_q <= req_bad ? '0 : rd_data_i;
    end
  end

  // Byte strobes to bit enables
  always_comb begin
    for (int i = 0; i < CSR_DATA_W / 8; i++) begin
      wr_biten_o[8*i +: 8] = {8{wstrb_q[i]}};
    end
  end

  assign req_o       = (state_q == StReq) & ~req_bad;
  assign req_is_wr_o = is_wr_q;
  assign addr_o      = addr_q;
  assign wr_data_o   = wdata_q;

  assign bvalid_o = (state_q == StResp) & is_wr_q;
  assign bresp_o  = resp_q;
  assign bid_o    = id_q;
  assign rvalid_o = (state_q == StResp) & ~is_wr_q;
  assign rresp_o  = resp_q;
  assign rid_o    = id_q;
  assign rdata_o  = rdata_q;
  assign rlast_o  = rvalid_o; // Single beat

endmodule

// ==== recovery_csr.sv ====
/* Mailbox registers, answered one cycle after each request.
   DATA writes spend one credit and fail without one; the FIFO returns a credit per pop.
   FifoDepth must not exceed 63 to fit the STATUS credit field */
`timescale 1ns/1ps
module recovery_csr #(
  parameter  int unsigned FifoDepth = 16,
  localparam int unsigned LevelW    = $clog2(FifoDepth + 1)
) (
  input  logic                                     aclk,
  input  logic                                     areset_n,
  // Request port
  input  logic                                     req_i,
  input  logic                                     req_is_wr_i,
  input  logic [11:0]                              addr_i,
  input  logic [recovery_mbox_pkg::CSR_DATA_W-1:0] wr_data_i,
  input  logic [recovery_mbox_pkg::CSR_DATA_W-1:0] wr_biten_i,
  output logic                                     ack_o,
  output logic                                     err_o,
  output logic [recovery_mbox_pkg::CSR_DATA_W-1:0] rd_data_o,
  // FIFO side
  output logic                                     push_o,
  output logic [recovery_mbox_pkg::CSR_DATA_W-1:0] push_data_o,
  output logic                                     pop_o,
  input  logic [recovery_mbox_pkg::CSR_DATA_W-1:0] pop_data_i,
  output logic                                     clear_o,
  input  logic [LevelW-1:0]                        level_i,
  input  logic                                     credit_i
);
  import recovery_mbox_pkg::*;

  logic [LevelW-1:0]     credits_q;
  logic [CSR_DATA_W-1:0] scratch_q;
  logic                  sel_ctrl;
  logic                  sel_status;
  logic                  sel_data;
  logic                  sel_scratch;
  logic                  wr_req;
  logic                  rd_req;
  logic                  fifo_empty;
  logic                  have_credit;
  status_word_u          status_w;
  logic                  err_d;
  logic [CSR_DATA_W-1:0] rd_data_d;

  assign sel_ctrl    = addr_i == CTRL_OFFS;
  assign sel_status  = addr_i == STATUS_OFFS;
  assign sel_data    = addr_i == DATA_OFFS;
  assign sel_scratch = addr_i == SCRATCH_OFFS;

  assign wr_req      = req_i & req_is_wr_i;
  assign rd_req      = req_i & ~req_is_wr_i;
  assign fifo_empty  = level_i == '0;
  assign have_credit = credits_q != '0;

  // FIFO strobes in the request cycle
  assign push_o      = wr_req & sel_data & have_credit;
  assign push_data_o = wr_data_i;
  assign pop_o       = rd_req & sel_data & ~fifo_empty;
  assign clear_o     = wr_req & sel_ctrl & wr_data_i[0];

  always_comb begin
    status_w.raw            = '0;
    status_w.fields.level   = 8'(level_i);
    status_w.fields.full    = level_i == LevelW'(FifoDepth);
    status_w.fields.empty   = fifo_empty;
    status_w.fields.credits = 6'(credits_q);
  end

  always_comb begin
    err_d     = 1'b0;
    rd_data_d = '0;
    if (sel_data) begin
      err_d = req_is_wr_i ? ~have_credit : fifo_empty;
    end else if (!(sel_ctrl || sel_status || sel_scratch)) begin
      err_d = 1'b1; // Unmapped
    end
    if (!req_is_wr_i) begin
      if (sel_status) rd_data_d = status_w.raw;
      else if (sel_scratch) rd_data_d = scratch_q;
      else if (sel_data && !fifo_empty) rd_data_d = pop_data_i;
    end
  end

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      ack_o     <= 1'b0;
      err_o     <= 1'b0;
      scratch_q <= '0;
      credits_q <= LevelW'(FifoDepth);
    end else begin
      ack_o <= req_i;
      err_o <= req_i & err_d;
      if (wr_req && sel_scratch) begin
        scratch_q <= (scratch_q & ~wr_biten_i) | (wr_data_i & wr_biten_i);
      end
      if (clear_o) credits_q <= LevelW'(FifoDepth);
      else credits_q <= credits_q - LevelW'(push_o) + LevelW'(credit_i);
    end
  end

  always_ff @(posedge aclk) begin
    if (req_i) rd_data_o <= rd_data_d;
  end

endmodule

// ==== indirect_fifo.sv ====
/* Circular buffer with the head word shown combinationally.
   It never checks full; the writer holds credits. Clear returns no credits */
`timescale 1ns/1ps
module indirect_fifo #(
  parameter  int unsigned Depth  = 16,
  localparam int unsigned PtrW   = (Depth > 1) ? $clog2(Depth) : 1,
  localparam int unsigned LevelW = $clog2(Depth + 1)
) (
  input  logic                                     aclk,
  input  logic                                     areset_n,
  input  logic                                     push_i,
  input  logic [recovery_mbox_pkg::CSR_DATA_W-1:0] push_data_i,
  input  logic                                     pop_i,
  output logic [recovery_mbox_pkg::CSR_DATA_W-1:0] pop_data_o,
  input  logic                                     clear_i,
  output logic [LevelW-1:0]                        level_o,
  output logic                                     credit_o
);
  import recovery_mbox_pkg::*;

  logic [CSR_DATA_W-1:0] mem_q [Depth];
  logic [PtrW-1:0]       rd_ptr_q;
  logic [PtrW-1:0]       wr_ptr_q;
  logic [LevelW-1:0]     level_q;
  logic                  credit_q;

  // Wraps for any depth
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop_data_o = mem_q[rd_ptr_q];
  assign level_o    = level_q;
  assign credit_o   = credit_q;

  always_ff @(posedge aclk) begin
    if (push_i) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q  <= '0;
      credit_q <= 1'b0;
    end else if (clear_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i) rd_ptr_q <= ptr_inc(rd_ptr_q);
      level_q  <= level_q + LevelW'(push_i) - LevelW'(pop_i);
      credit_q <= pop_i; // One credit back per pop
    end
  end

endmodule

// ==== recovery_mbox_top.sv ====
/* Recovery mailbox behind an AXI4 slave port.
   AddrW must be at least 12; only the low 12 address bits select a register */
`timescale 1ns/1ps
module recovery_mbox_top #(
  parameter int unsigned FifoDepth = 16,
  parameter int unsigned AddrW     = 12,
  parameter int unsigned IdW       = 4
) (
  input  logic                                       aclk,
  input  logic                                       areset_n,
  input  logic [AddrW-1:0]                           awaddr_i,
  input  logic [IdW-1:0]                             awid_i,
  input  logic [7:0]                                 awlen_i,
  input  logic                                       awvalid_i,
  output logic                                       awready_o,
  input  logic [recovery_mbox_pkg::CSR_DATA_W-1:0]   wdata_i,
  input  logic [recovery_mbox_pkg::CSR_DATA_W/8-1:0] wstrb_i,
  input  logic                                       wlast_i,
  input  logic                                       wvalid_i,
  output logic                                       wready_o,
  output logic [1:0]                                 bresp_o,
  output logic [IdW-1:0]                             bid_o,
  output logic                                       bvalid_o,
  input  logic                                       bready_i,
  input  logic [AddrW-1:0]                           araddr_i,
  input  logic [IdW-1:0]                             arid_i,
  input  logic [7:0]                                 arlen_i,
  input  logic                                       arvalid_i,
  output logic                                       arready_o,
  output logic [recovery_mbox_pkg::CSR_DATA_W-1:0]   rdata_o,
  output logic [1:0]                                 rresp_o,
  output logic [IdW-1:0]                             rid_o,
  output logic                                       rlast_o,
  output logic                                       rvalid_o,
  input  logic                                       rready_i
);
  import recovery_mbox_pkg::*;

  localparam int unsigned LevelW = $clog2(FifoDepth + 1);

  // Register request path
  logic                  csr_req;
  logic                  csr_is_wr;
  logic [AddrW-1:0]      csr_addr;
  logic [CSR_DATA_W-1:0] csr_wdata;
  logic [CSR_DATA_W-1:0] csr_biten;
  logic                  csr_ack;
  logic                  csr_err;
  logic [CSR_DATA_W-1:0] csr_rdata;
  // FIFO path
  logic                  fifo_push;
  logic [CSR_DATA_W-1:0] fifo_push_data;
  logic                  fifo_pop;
  logic [CSR_DATA_W-1:0] fifo_pop_data;
  logic                  fifo_clear;
  logic [LevelW-1:0]     fifo_level;
  logic                  fifo_credit;

  axi_csr_adapter #(
    .AddrW(AddrW),
    .IdW  (IdW)
  ) u_adapter (
    .aclk       (aclk),
    .areset_n   (areset_n),
    .awaddr_i   (awaddr_i),
    .awid_i     (awid_i),
    .awlen_i    (awlen_i),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .wlast_i    (wlast_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .bresp_o    (bresp_o),
    .bid_o      (bid_o),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .araddr_i   (araddr_i),
    .arid_i     (arid_i),
    .arlen_i    (arlen_i),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rid_o      (rid_o),
    .rlast_o    (rlast_o),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .req_o      (csr_req),
    .req_is_wr_o(csr_is_wr),
    .addr_o     (csr_addr),
    .wr_data_o  (csr_wdata),
    .wr_biten_o (csr_biten),
    .ack_i      (csr_ack),
    .err_i      (csr_err),
    .rd_data_i  (csr_rdata)
  );

  recovery_csr #(
    .FifoDepth(FifoDepth)
  ) u_csr (
    .aclk       (aclk),
    .areset_n   (areset_n),
    .req_i      (csr_req),
    .req_is_wr_i(csr_is_wr),
    .addr_i     (csr_addr[11:0]), // Register offset only
    .wr_data_i  (csr_wdata),
    .wr_biten_i (csr_biten),
    .ack_o      (csr_ack),
    .err_o      (csr_err),
    .rd_data_o  (csr_rdata),
    .push_o     (fifo_push),
    .push_data_o(fifo_push_data),
    .pop_o      (fifo_pop),
    .pop_data_i (fifo_pop_data),
    .clear_o    (fifo_clear),
    .level_i    (fifo_level),
    .credit_i   (fifo_credit)
  );

  indirect_fifo #(
    .Depth(FifoDepth)
  ) u_fifo (
    .aclk       (aclk),
    .areset_n   (areset_n),
    .push_i     (fifo_push),
    .push_data_i(fifo_push_data),
    .pop_i      (fifo_pop),
    .pop_data_o (fifo_pop_data),
    .clear_i    (fifo_clear),
    .level_o    (fifo_level),
    .credit_o   (fifo_credit)
  );

endmodule

// ==== recovery_mbox_sva.sv ====
/* AXI response checks bound into the mailbox top level.
   Reads are single beat, so rlast goes with every rvalid */
`timescale 1ns/1ps
module recovery_mbox_sva #(
  parameter int unsigned IdW = 4
) (
  input logic                                     aclk,
  input logic                                     areset_n,
  input logic                                     bvalid_o,
  input logic                                     bready_i,
  input logic [1:0]                               bresp_o,
  input logic [IdW-1:0]                           bid_o,
  input logic                                     rvalid_o,
  input logic                                     rready_i,
  input logic [1:0]                               rresp_o,
  input logic [IdW-1:0]                           rid_o,
  input logic [recovery_mbox_pkg::CSR_DATA_W-1:0] rdata_o,
  input logic                                     rlast_o
);

  b_hold: assert property (@(posedge aclk) disable iff (!areset_n)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o) && $stable(bid_o))
    else $error("Write response dropped or changed before bready");

  // Data and id must not move while the host stalls
  r_hold: assert property (@(posedge aclk) disable iff (!areset_n)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rresp_o) && $stable(rid_o)
      && $stable(rdata_o))
    else $error("Read response dropped or changed before rready");

  r_last: assert property (@(posedge aclk) disable iff (!areset_n) rvalid_o |-> rlast_o)
    else $error("rvalid without rlast");

endmodule

bind recovery_mbox_top recovery_mbox_sva #(.IdW(IdW)) u_sva (
  .aclk    (aclk),
  .areset_n(areset_n),
  .bvalid_o(bvalid_o),
  .bready_i(bready_i),
  .bresp_o (bresp_o),
  .bid_o   (bid_o),
  .rvalid_o(rvalid_o),
  .rready_i(rready_i),
  .rresp_o (rresp_o),
  .rid_o   (rid_o),
  .rdata_o (rdata_o),
  .rlast_o (rlast_o)
);

// ==== recovery_mbox_tb.sv ====
/* Random single-beat AXI traffic against a reference model of the mailbox.
   Assumes FifoDepth 16 and one transaction on the bus at a time */
`timescale 1ns/1ps
module recovery_mbox_tb;
  import recovery_mbox_pkg::*;

  localparam int unsigned Depth       = 16;
  localparam int unsigned NumRandom   = 400;
  localparam int unsigned NumDirected = 3 * (Depth + 1) + 8;
  localparam int unsigned NumTxn      = NumRandom + NumDirected;
  localparam realtime     ClkPeriod   = 8.0;

  logic        aclk;
  logic        areset_n;
  logic [11:0] awaddr_i;
  logic [11:0] araddr_i;
  logic [3:0]  awid_i;
  logic [3:0]  arid_i;
  logic [3:0]  bid_o;
  logic [3:0]  rid_o;
  logic [7:0]  awlen_i;
  logic [7:0]  arlen_i;
  logic [31:0] wdata_i;
  logic [31:0] rdata_o;
  logic [3:0]  wstrb_i;
  logic [1:0]  bresp_o;
  logic [1:0]  rresp_o;
  logic        awvalid_i;
  logic        awready_o;
  logic        wlast_i;
  logic        wvalid_i;
  logic        wready_o;
  logic        bvalid_o;
  logic        bready_i;
  logic        arvalid_i;
  logic        arready_o;
  logic        rlast_o;
  logic        rvalid_o;
  logic        rready_i;

  logic [31:0] lcg_state;
  logic [31:0] scratch_m;   // Model of SCRATCH
  logic [31:0] fifo_m[$];   // Model of the FIFO contents
  int unsigned errors;
  int unsigned checks;

  recovery_mbox_top #(.FifoDepth(Depth)) UUT (.*);

  initial begin
    aclk = 1'b0;
    forever #(ClkPeriod / 2) aclk = ~aclk;
  end

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16]; // Upper half, the low bits cycle too fast
  endfunction

  function automatic logic [31:0] rand_word();
    logic [15:0] hi;
    hi = next_rand();
    return {hi, next_rand()};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic transfer(input logic is_wr, input logic [11:0] addr, input logic [3:0] id,
                          input logic [31:0] data, input logic [3:0] strb,
                          input logic [7:0] len, input logic last, output logic [1:0] resp,
                          output logic [3:0] rsp_id, output logic [31:0] rd_data);
    int unsigned stall;
    logic        accepted;
    stall    = next_rand() % 4;
    accepted = 1'b0;
    if (is_wr) begin
      awaddr_i  = addr;
      awid_i    = id;
      awlen_i   = len;
      wdata_i   = data;
      wstrb_i   = strb;
      wlast_i   = last;
      awvalid_i = 1'b1;
      wvalid_i  = 1'b1;
    end else begin
      araddr_i  = addr;
      arid_i    = id;
      arlen_i   = len;
      arvalid_i = 1'b1;
    end
    while (!accepted) begin
      @(negedge aclk);
      accepted = is_wr ? (awready_o && wready_o) : arready_o;
      @(posedge aclk);
      #1;
    end
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    arvalid_i = 1'b0;
    @(negedge aclk);
    while (!(is_wr ? bvalid_o : rvalid_o)) @(negedge aclk);
    repeat (stall) @(negedge aclk); // Response waits with ready low
    @(posedge aclk);
    #1;
    bready_i = is_wr;
    rready_i = !is_wr;
    @(negedge aclk);
    resp    = is_wr ? bresp_o : rresp_o;
    rsp_id  = is_wr ? bid_o : rid_o;
    rd_data = rdata_o;
    @(posedge aclk);
    #1;
    bready_i = 1'b0;
    rready_i = 1'b0;
  endtask

  task automatic write_check(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [7:0] len, input logic last);
    logic [1:0]  exp_resp;
    logic [1:0]  resp;
    logic [3:0]  id;
    logic [3:0]  rsp_id;
    logic [31:0] rd_data;
    id       = 4'(next_rand());
    exp_resp = RESP_OKAY;
    if (len != 0 || !last) begin
      exp_resp = RESP_SLVERR;
    end else if (addr == CTRL_OFFS) begin
      if (data[0]) fifo_m.delete();
    end else if (addr == DATA_OFFS) begin
      if (fifo_m.size() < Depth) fifo_m.push_back(data);
      else exp_resp = RESP_SLVERR; // No credit left
    end else if (addr == SCRATCH_OFFS) begin
      // Only the strobed bytes take new data
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) scratch_m[8*i +: 8] = data[8*i +: 8];
      end
    end else if (addr != STATUS_OFFS) begin
      exp_resp = RESP_SLVERR;
    end
    transfer(1'b1, addr, id, data, strb, len, last, resp, rsp_id, rd_data);
    check_value("bresp", 32'(resp), 32'(exp_resp));
    check_value("bid", 32'(rsp_id), 32'(id));
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [7:0] len);
    logic [1:0]   exp_resp;
    logic [31:0]  exp_data;
    logic [1:0]   resp;
    logic [3:0]   id;
    logic [3:0]   rsp_id;
    logic [31:0]  rd_data;
    status_word_u status;
    int unsigned  level;
    id       = 4'(next_rand());
    exp_resp = RESP_OKAY;
    exp_data = '0;
    level    = fifo_m.size();
    if (len != 0) begin
      exp_resp = RESP_SLVERR;
    end else if (addr == DATA_OFFS) begin
      if (level == 0) exp_resp = RESP_SLVERR;
      else exp_data = fifo_m.pop_front();
    end else if (addr == SCRATCH_OFFS) begin
      exp_data = scratch_m;
    end else if (addr != CTRL_OFFS && addr != STATUS_OFFS) begin
      exp_resp = RESP_SLVERR;
    end
    transfer(1'b0, addr, id, '0, '0, len, 1'b1, resp, rsp_id, rd_data);
    check_value("rresp", 32'(resp), 32'(exp_resp));
    check_value("rid", 32'(rsp_id), 32'(id));
    if (addr == STATUS_OFFS && len == 0) begin
      status.raw = rd_data;
      check_value("rdata.level", 32'(status.fields.level), level);
      check_value("rdata.full", 32'(status.fields.full), 32'(level == Depth));
      check_value("rdata.empty", 32'(status.fields.empty), 32'(level == 0));
      check_value("rdata.credits", 32'(status.fields.credits), Depth - level);
      check_value("rdata.reserved", 32'(status.fields.reserved), 32'h0);
    end else begin
      check_value("rdata", rd_data, exp_data);
    end
  endtask

  initial begin
    logic [11:0] addr;
    logic [7:0]  len;
    int unsigned pick;
    areset_n  = 1'b0;
    awaddr_i  = '0;
    awid_i    = '0;
    awlen_i   = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wlast_i   = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arid_i    = '0;
    arlen_i   = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    lcg_state = 32'd7265;
    scratch_m = '0;
    errors    = 0;
    checks    = 0;
    repeat (8) @(posedge aclk);
    #1;
    areset_n = 1'b1;
    check_value("awready,wready,arready,bvalid,rvalid",
                32'({awready_o, wready_o, arready_o, bvalid_o, rvalid_o}), 32'b11100);

    // Fill one past the depth, then drain one past empty
    for (int i = 0; i <= Depth; i++) begin
      write_check(DATA_OFFS, rand_word(), 4'hF, 8'd0, 1'b1);
      read_check(STATUS_OFFS, 8'd0);
    end
    for (int i = 0; i <= Depth; i++) read_check(DATA_OFFS, 8'd0);
    for (int i = 0; i < 5; i++) write_check(DATA_OFFS, rand_word(), 4'hF, 8'd0, 1'b1);
    write_check(CTRL_OFFS, 32'h1, 4'hF, 8'd0, 1'b1);
    read_check(STATUS_OFFS, 8'd0);
    read_check(DATA_OFFS, 8'd0);

    for (int n = 0; n < NumRandom; n++) begin
      pick = next_rand() % 20;
      case (pick)
        0, 1, 2, 3, 4, 5, 6: write_check(DATA_OFFS, rand_word(), 4'(next_rand()), 8'd0, 1'b1);
        7, 8, 9, 10, 11, 12: read_check(DATA_OFFS, 8'd0);
        13: write_check(STATUS_OFFS, rand_word(), 4'hF, 8'd0, 1'b1);
        14: read_check(STATUS_OFFS, 8'd0);
        15: write_check(SCRATCH_OFFS, rand_word(), 4'(next_rand()), 8'd0, 1'b1);
        16: read_check(SCRATCH_OFFS, 8'd0);
        17: write_check(CTRL_OFFS, rand_word(), 4'hF, 8'd0, 1'b1);
        18: begin
          addr = 12'(next_rand()) | 12'h010; // Never a mapped offset
          if (next_rand() % 2) write_check(addr, rand_word(), 4'hF, 8'd0, 1'b1);
          else read_check(addr, 8'd0);
        end
        default: begin
          addr = 12'((next_rand() % 4) * 4);
          len  = 8'(next_rand());
          // len 0 goes with a missing wlast
          if (next_rand() % 2) write_check(addr, rand_word(), 4'hF, len, len != 0);
          else read_check(addr, 8'(1 + next_rand() % 255));
        end
      endcase
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    repeat (NumTxn * 40 + 8) @(posedge aclk);
    $display("Timeout: the transactions did not complete within %0d cycles", NumTxn * 40);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== recovery_mbox.f ====
recovery_mbox_pkg.sv
axi_csr_adapter.sv
recovery_csr.sv
indirect_fifo.sv
recovery_mbox_top.sv
recovery_mbox_sva.sv
recovery_mbox_tb.sv

// ==== Bender.yml ====
package:
  name: recovery_mbox

sources:
  - recovery_mbox_pkg.sv
  - axi_csr_adapter.sv
  - recovery_csr.sv
  - indirect_fifo.sv
  - recovery_mbox_top.sv
  - target: simulation
    files:
      - recovery_mbox_sva.sv
      - recovery_mbox_tb.sv
